/* logic/cvp_settings.svh */
`ifndef CVP_SETTINGS_SVH
`define CVP_SETTINGS_SVH

// Data, address and instruction width
`define CVP_WORD_W 16

// Lanes per vector register
`define CVP_LANES 16
`define CVP_VEC_W (`CVP_LANES * `CVP_WORD_W)

// Eight vector and eight scalar registers
`define CVP_REGS 8
`define CVP_REG_AW 3

// Reaches one past the last lane for the overlapped load
`define CVP_LANE_CW 5

// Positive infinity in half precision
`define CVP_FP_INF 16'h7C00

`endif

/* logic/cvp_pkg.sv */
`default_nettype none

package cvp_pkg;

  // Instruction codes, bits 15..12 of the instruction word
  typedef enum logic [3:0] {
    VADD = 4'd0,
    SST  = 4'd3,
    VLD  = 4'd4,
    VST  = 4'd5,
    SLL  = 4'd6,
    SLH  = 4'd7,
    J    = 4'd8,
    NOP  = 4'd15
  } opcode_e;

  // Sequencer states
  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    EXECUTE,
    ADD,        // One lane per cycle
    LOAD,
    STORE,
    JUMP,
    WRITEBACK
  } state_e;

endpackage

`default_nettype wire

/* logic/fp16_adder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cvp_settings.svh"

module fp16_adder (
  input  wire logic [`CVP_WORD_W-1:0] a,
  input  wire logic [`CVP_WORD_W-1:0] b,
  output logic      [`CVP_WORD_W-1:0] sum,
  output logic                        inf
);

  localparam logic [15:0] POS_INF = `CVP_FP_INF;

  logic        a_inf, b_inf;
  logic        sub, sign_r, round_up;
  logic [15:0] op_big, op_small;
  logic [4:0]  e_big, e_small, diff;
  logic [10:0] m_big, m_small;   // Hidden bit plus fraction
  logic [13:0] aligned, lost;    // Significand with guard, round, sticky
  logic [14:0] raw;              // One extra bit for carry out
  logic [13:0] norm;
  logic [3:0]  lz;
  logic [5:0]  exp_n;
  logic [15:0] packed_r;

  always_comb begin
    a_inf = &a[14:10];
    b_inf = &b[14:10];

    // Larger magnitude goes first so subtraction never goes negative
    op_big   = (a[14:0] >= b[14:0]) ? a : b;
    op_small = (a[14:0] >= b[14:0]) ? b : a;

    // Denormals use exponent 1 with a zero hidden bit
    e_big   = (op_big[14:10] == 5'd0) ? 5'd1 : op_big[14:10];
    e_small = (op_small[14:10] == 5'd0) ? 5'd1 : op_small[14:10];
    m_big   = {|op_big[14:10], op_big[9:0]};
    m_small = {|op_small[14:10], op_small[9:0]};

    // Align, folding every shifted-out bit into sticky
    diff       = e_big - e_small;
    aligned    = {m_small, 3'b000} >> diff;
    lost       = {m_small, 3'b000} & ((14'd1 << diff) - 14'd1);
    aligned[0] = aligned[0] | (|lost);

    sub = op_big[15] ^ op_small[15];
    if (sub) begin
      raw = {1'b0, m_big, 3'b000} - {1'b0, aligned};
    end else begin
      raw = {1'b0, m_big, 3'b000} + {1'b0, aligned};
    end
    sign_r = (sub && raw == '0) ? 1'b0 : op_big[15];  // Exact cancel gives +0

    // Highest set bit wins
    lz = 4'd0;
    for (int i = 0; i < 14; i++) begin
      if (raw[i]) begin
        lz = 4'(13 - i);
      end
    end

    if (raw[14]) begin
      norm  = {raw[14:2], raw[1] | raw[0]};  // Carry out, keep sticky
      exp_n = {1'b0, e_big} + 6'd1;
    end else if (raw == '0) begin
      norm  = '0;
      exp_n = '0;
    end else if (lz < e_big) begin
      norm  = raw[13:0] << lz;
      exp_n = {1'b0, e_big} - {2'b00, lz};
    end else begin
      // Result underflows into a denormal
      norm  = raw[13:0] << (e_big - 5'd1);
      exp_n = '0;
    end

    // Round to nearest even; a carry out of the fraction renormalizes
    // into the exponent field on its own
    round_up = norm[2] & (norm[1] | norm[0] | norm[3]);
    packed_r = {exp_n, norm[12:3]} + {15'd0, round_up};

    if (a_inf || b_inf) begin
      inf = 1'b1;
      sum = {(a_inf ? a[15] : b[15]), POS_INF[14:0]};
    end else if (packed_r[15:10] >= 6'd31) begin
      inf = 1'b1;                             // Exponent overflow
      sum = {sign_r, POS_INF[14:0]};
    end else begin
      inf = 1'b0;
      sum = {sign_r, packed_r[14:0]};
    end
  end

endmodule

`default_nettype wire

/* logic/instr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cvp_settings.svh"

module instr_decoder import cvp_pkg::*; (
  input  wire logic [`CVP_WORD_W-1:0] instr,
  output opcode_e                     opcode,
  output logic      [`CVP_REG_AW-1:0] rd_field,
  output logic      [`CVP_REG_AW-1:0] ra_field,
  output logic      [`CVP_REG_AW-1:0] rb_field,
  output logic      [7:0]             imm,
  output logic      [5:0]             mem_offset,
  output logic      [11:0]            jump_offset
);

  logic [3:0] op_bits;

  assign op_bits = instr[`CVP_WORD_W-1 -: 4];

  // Dropped or unassigned codes fall back to NOP
  always_comb begin
    case (op_bits)
      VADD, SST, VLD, VST, SLL, SLH, J: opcode = opcode_e'(op_bits);
      default:                          opcode = NOP;
    endcase
  end

  assign rd_field    = instr[11:9];  // Also the store data register
  assign ra_field    = instr[8:6];
  assign rb_field    = instr[5:3];
  assign imm         = instr[7:0];
  assign mem_offset  = instr[5:0];   // Unsigned, added to scalar ra
  assign jump_offset = instr[11:0];  // Signed, relative to the J address

endmodule

`default_nettype wire

/* logic/register_bank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cvp_settings.svh"

module register_bank (
  input  wire logic                   Clk1,
  input  wire logic                   rst_n,
  input  wire logic [`CVP_REG_AW-1:0] vrd_addr_a,
  input  wire logic [`CVP_REG_AW-1:0] vrd_addr_b,
  input  wire logic [`CVP_REG_AW-1:0] srd_addr_a,
  input  wire logic [`CVP_REG_AW-1:0] srd_addr_b,
  output logic      [`CVP_VEC_W-1:0]  vec_a,
  output logic      [`CVP_VEC_W-1:0]  vec_b,
  output logic      [`CVP_WORD_W-1:0] scal_a,
  output logic      [`CVP_WORD_W-1:0] scal_b,
  input  wire logic                   vwr_en,
  input  wire logic                   swr_en,
  input  wire logic [`CVP_REG_AW-1:0] wr_addr,
  input  wire logic [`CVP_VEC_W-1:0]  vwr_data,
  input  wire logic [`CVP_WORD_W-1:0] swr_data
);

  logic [`CVP_VEC_W-1:0]  vregs [`CVP_REGS];
  logic [`CVP_WORD_W-1:0] sregs [`CVP_REGS];

  // All registers start from zero
  always_ff @(posedge Clk1 or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CVP_REGS; i++) begin
        vregs[i] <= '0;
        sregs[i] <= '0;
      end
    end else begin
      if (vwr_en) begin
        vregs[wr_addr] <= vwr_data;
      end
      if (swr_en) begin
        sregs[wr_addr] <= swr_data;
      end
    end
  end

  // Reads are combinational
  assign vec_a  = vregs[vrd_addr_a];
  assign vec_b  = vregs[vrd_addr_b];
  assign scal_a = sregs[srd_addr_a];
  assign scal_b = sregs[srd_addr_b];

endmodule

`default_nettype wire

/* logic/cvp_control.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cvp_settings.svh"

module cvp_control import cvp_pkg::*; (
  input  wire logic                   Clk1,
  input  wire logic                   rst_n,
  input  wire logic [`CVP_WORD_W-1:0] data_in,
  output logic      [`CVP_WORD_W-1:0] addr,
  output logic                        rd,
  output logic                        wr,
  output logic      [`CVP_WORD_W-1:0] data_out,
  output logic                        v,
  output logic      [`CVP_WORD_W-1:0] instr,
  input  wire opcode_e                opcode,
  input  wire logic [`CVP_REG_AW-1:0] rd_field,
  input  wire logic [`CVP_REG_AW-1:0] ra_field,
  input  wire logic [`CVP_REG_AW-1:0] rb_field,
  input  wire logic [7:0]             imm,
  input  wire logic [5:0]             mem_offset,
  input  wire logic [11:0]            jump_offset,
  output logic      [`CVP_REG_AW-1:0] vrd_addr_a,
  output logic      [`CVP_REG_AW-1:0] vrd_addr_b,
  output logic      [`CVP_REG_AW-1:0] srd_addr_a,
  output logic      [`CVP_REG_AW-1:0] srd_addr_b,
  input  wire logic [`CVP_VEC_W-1:0]  vec_a,
  input  wire logic [`CVP_VEC_W-1:0]  vec_b,
  input  wire logic [`CVP_WORD_W-1:0] scal_a,
  input  wire logic [`CVP_WORD_W-1:0] scal_b,
  output logic                        vwr_en,
  output logic                        swr_en,
  output logic      [`CVP_REG_AW-1:0] wr_addr,
  output logic      [`CVP_VEC_W-1:0]  vwr_data,
  output logic      [`CVP_WORD_W-1:0] swr_data,
  output logic      [`CVP_WORD_W-1:0] add_a,
  output logic      [`CVP_WORD_W-1:0] add_b,
  input  wire logic [`CVP_WORD_W-1:0] add_sum,
  input  wire logic                   add_inf
);

  localparam logic [`CVP_LANE_CW-1:0] LAST_LANE = `CVP_LANE_CW'(`CVP_LANES - 1);
  localparam logic [`CVP_LANE_CW-1:0] LOAD_LAST = `CVP_LANE_CW'(`CVP_LANES);

  state_e                   state, state_nxt;
  logic                     run;       // Holds off the first fetch until a clock after reset
  logic [`CVP_WORD_W-1:0]   pc;
  logic [`CVP_LANE_CW-1:0]  lane_cnt, lane_prev;
  logic [`CVP_LANE_CW-2:0]  lane;
  logic [`CVP_VEC_W-1:0]    vec_acc;   // Vector being assembled
  logic                     ovf_acc;
  logic [`CVP_WORD_W-1:0]   mem_base, lane_ext, jump_target;

  assign lane        = lane_cnt[`CVP_LANE_CW-2:0];
  assign lane_prev   = lane_cnt - 1'b1;  // Lane whose read data arrives now
  assign lane_ext    = {{(`CVP_WORD_W-`CVP_LANE_CW){1'b0}}, lane_cnt};
  assign mem_base    = scal_a + {{(`CVP_WORD_W-6){1'b0}}, mem_offset};
  assign jump_target = pc + {{(`CVP_WORD_W-12){jump_offset[11]}}, jump_offset};

  always_comb begin
    state_nxt = state;
    case (state)
      FETCH:   if (run) state_nxt = DECODE;
      DECODE:  state_nxt = EXECUTE;
      EXECUTE: begin
        case (opcode)
          VADD:     state_nxt = ADD;
          VLD:      state_nxt = LOAD;
          VST, SST: state_nxt = STORE;
          J:        state_nxt = JUMP;
          default:  state_nxt = WRITEBACK;
        endcase
      end
      ADD:     if (lane_cnt == LAST_LANE) state_nxt = WRITEBACK;
      LOAD:    if (lane_cnt == LOAD_LAST) state_nxt = WRITEBACK;
      STORE:   if (opcode == SST || lane_cnt == LAST_LANE) state_nxt = FETCH;
      default: state_nxt = FETCH;  // JUMP and WRITEBACK
    endcase
  end

  always_ff @(posedge Clk1 or negedge rst_n) begin
    if (!rst_n) begin
      state    <= FETCH;
      run      <= 1'b0;
      pc       <= '0;
      lane_cnt <= '0;
      ovf_acc  <= 1'b0;
      v        <= 1'b0;
    end else begin
      state <= state_nxt;
      run   <= 1'b1;
      if (state == EXECUTE) begin
        lane_cnt <= '0;
        ovf_acc  <= 1'b0;
      end else if (state == ADD || state == LOAD || state == STORE) begin
        lane_cnt <= lane_cnt + 1'b1;
      end
      if (state == ADD) begin
        ovf_acc <= ovf_acc | add_inf;
      end
      if (state == JUMP) begin
        pc <= jump_target;
      end else if (state != FETCH && state_nxt == FETCH) begin
        pc <= pc + 1'b1;
      end
      // Flag follows the last VADD only
      if (state == WRITEBACK && opcode == VADD) begin
        v <= ovf_acc;
      end
    end
  end

  always_ff @(posedge Clk1) begin
    if (state == DECODE) begin
      instr <= data_in;
    end
    if (state == ADD) begin
      vec_acc[lane*`CVP_WORD_W +: `CVP_WORD_W] <= add_sum;
    end
    // Data lags the read strobe by one cycle
    if (state == LOAD && lane_cnt != '0) begin
      vec_acc[lane_prev[`CVP_LANE_CW-2:0]*`CVP_WORD_W +: `CVP_WORD_W] <= data_in;
    end
  end

  // Memory port
  always_comb begin
    rd   = 1'b0;
    wr   = 1'b0;
    addr = pc;
    case (state)
      FETCH: rd = run;
      LOAD: begin
        addr = mem_base + lane_ext;
        rd   = (lane_cnt != LOAD_LAST);  // Last cycle only collects data
      end
      STORE: begin
        addr = mem_base + lane_ext;
        wr   = 1'b1;
      end
      default: addr = pc;
    endcase
  end

  assign data_out = (opcode == SST) ? scal_b : vec_b[lane*`CVP_WORD_W +: `CVP_WORD_W];

  // Operand selection
  assign vrd_addr_a = ra_field;
  assign vrd_addr_b = (opcode == VST) ? rd_field : rb_field;
  assign srd_addr_a = ra_field;   // Address base
  assign srd_addr_b = rd_field;   // Store data or the byte merge source
  assign add_a      = vec_a[lane*`CVP_WORD_W +: `CVP_WORD_W];
  assign add_b      = vec_b[lane*`CVP_WORD_W +: `CVP_WORD_W];

  // Register writeback
  assign wr_addr  = rd_field;
  assign vwr_en   = (state == WRITEBACK) && (opcode == VADD || opcode == VLD);
  assign swr_en   = (state == WRITEBACK) && (opcode == SLL || opcode == SLH);
  assign vwr_data = vec_acc;
  assign swr_data = (opcode == SLH) ? {imm, scal_b[7:0]} : {scal_b[`CVP_WORD_W-1:8], imm};

endmodule

`default_nettype wire

/* logic/cvp_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cvp_settings.svh"

module cvp_core import cvp_pkg::*; (
  input  wire logic                   Clk1,
  input  wire logic                   rst_n,
  input  wire logic [`CVP_WORD_W-1:0] data_in,
  output logic      [`CVP_WORD_W-1:0] addr,
  output logic                        rd,
  output logic                        wr,
  output logic      [`CVP_WORD_W-1:0] data_out,
  output logic                        v
);

  // Decoded instruction
  logic [`CVP_WORD_W-1:0] instr;
  opcode_e                opcode;
  logic [`CVP_REG_AW-1:0] rd_field, ra_field, rb_field;
  logic [7:0]             imm;
  logic [5:0]             mem_offset;
  logic [11:0]            jump_offset;

  // Register file ports
  logic [`CVP_REG_AW-1:0] vrd_addr_a, vrd_addr_b, srd_addr_a, srd_addr_b;
  logic [`CVP_VEC_W-1:0]  vec_a, vec_b;
  logic [`CVP_WORD_W-1:0] scal_a, scal_b;
  logic                   vwr_en, swr_en;
  logic [`CVP_REG_AW-1:0] wr_addr;
  logic [`CVP_VEC_W-1:0]  vwr_data;
  logic [`CVP_WORD_W-1:0] swr_data;

  // Lane adder
  logic [`CVP_WORD_W-1:0] add_a, add_b, add_sum;
  logic                   add_inf;

  cvp_control control_i (
    .Clk1        (Clk1),        .rst_n      (rst_n),
    .data_in     (data_in),     .addr       (addr),
    .rd          (rd),          .wr         (wr),
    .data_out    (data_out),    .v          (v),
    .instr       (instr),       .opcode     (opcode),
    .rd_field    (rd_field),    .ra_field   (ra_field),
    .rb_field    (rb_field),    .imm        (imm),
    .mem_offset  (mem_offset),  .jump_offset(jump_offset),
    .vrd_addr_a  (vrd_addr_a),  .vrd_addr_b (vrd_addr_b),
    .srd_addr_a  (srd_addr_a),  .srd_addr_b (srd_addr_b),
    .vec_a       (vec_a),       .vec_b      (vec_b),
    .scal_a      (scal_a),      .scal_b     (scal_b),
    .vwr_en      (vwr_en),      .swr_en     (swr_en),
    .wr_addr     (wr_addr),     .vwr_data   (vwr_data),
    .swr_data    (swr_data),    .add_a      (add_a),
    .add_b       (add_b),       .add_sum    (add_sum),
    .add_inf     (add_inf)
  );

  instr_decoder decoder_i (
    .instr       (instr),
    .opcode      (opcode),
    .rd_field    (rd_field),
    .ra_field    (ra_field),
    .rb_field    (rb_field),
    .imm         (imm),
    .mem_offset  (mem_offset),
    .jump_offset (jump_offset)
  );

  register_bank regs_i (
    .Clk1        (Clk1),        .rst_n      (rst_n),
    .vrd_addr_a  (vrd_addr_a),  .vrd_addr_b (vrd_addr_b),
    .srd_addr_a  (srd_addr_a),  .srd_addr_b (srd_addr_b),
    .vec_a       (vec_a),       .vec_b      (vec_b),
    .scal_a      (scal_a),      .scal_b     (scal_b),
    .vwr_en      (vwr_en),      .swr_en     (swr_en),
    .wr_addr     (wr_addr),     .vwr_data   (vwr_data),
    .swr_data    (swr_data)
  );

  fp16_adder adder_i (
    .a   (add_a),
    .b   (add_b),
    .sum (add_sum),
    .inf (add_inf)
  );

endmodule

`default_nettype wire

/* testbench/cvp_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cvp_settings.svh"

module cvp_mem_model (
  input  wire logic                   Clk1,
  input  wire logic [`CVP_WORD_W-1:0] addr,
  input  wire logic                   rd,
  input  wire logic                   wr,
  input  wire logic [`CVP_WORD_W-1:0] wdata,
  output logic      [`CVP_WORD_W-1:0] rdata
);

  // 256 words, upper address bits ignored
  logic [`CVP_WORD_W-1:0] mem [256];
  logic                   written [256];  // Set by every store

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i]     = {~8'(i), 8'(i)};  // Background pattern
      written[i] = 1'b0;
    end
    rdata = '0;
  end

  // Read data follows the strobe by one cycle
  always @(posedge Clk1) begin
    if (rd) begin
      rdata <= mem[addr[7:0]];
    end
    if (wr) begin
      mem[addr[7:0]]     <= wdata;
      written[addr[7:0]] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* testbench/cvp_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cvp_settings.svh"

module cvp_tb import cvp_pkg::*; ();

  localparam int CLK_HALF  = 50;
  localparam int DRIVE_DLY = 1;
  localparam int PROG_LEN  = 20;
  localparam int HALT_ADDR = 19;   // J to itself
  localparam int MARGIN    = 50;

  logic                   Clk1 = 1'b0;
  logic                   rst_n;
  logic [`CVP_WORD_W-1:0] data_in, addr, data_out;
  logic                   rd, wr, v;

  logic [`CVP_WORD_W-1:0] prog [32];
  logic                   v_exp [32];      // Flag value at each fetch
  logic [`CVP_WORD_W-1:0] exp_mem [256];
  logic                   exp_valid [256];
  logic [`CVP_WORD_W-1:0] exp_fetch = '0;
  logic                   halted = 1'b0;
  int                     value_errs = 0;
  int                     proto_errs = 0;
  int                     miss_errs = 0;

  cvp_core dut_i (
    .Clk1     (Clk1),
    .rst_n    (rst_n),
    .data_in  (data_in),
    .addr     (addr),
    .rd       (rd),
    .wr       (wr),
    .data_out (data_out),
    .v        (v)
  );

  cvp_mem_model mem_i (
    .Clk1  (Clk1),
    .addr  (addr),
    .rd    (rd),
    .wr    (wr),
    .wdata (data_out),
    .rdata (data_in)
  );

  always #CLK_HALF Clk1 = ~Clk1;

  function automatic logic [15:0] mem_instr(opcode_e op, int rd_r, int ra_r, int offset);
    return {op, 3'(rd_r), 3'(ra_r), 6'(offset)};
  endfunction

  function automatic logic [15:0] vadd_instr(int rd_r, int ra_r, int rb_r);
    return {VADD, 3'(rd_r), 3'(ra_r), 3'(rb_r), 3'b000};
  endfunction

  // Documented cycle count of one instruction
  function automatic int instr_cycles(logic [3:0] op);
    case (op)
      VADD:    return 20;
      VLD:     return 21;
      VST:     return 19;
      default: return 4;
    endcase
  endfunction

  function automatic real half_to_real(logic [15:0] h);
    real m;
    int  e;
    e = (h[14:10] == 5'd0) ? 1 : int'(h[14:10]);
    m = (h[14:10] == 5'd0) ? 0.0 : 1.0;  // Hidden bit
    m = m + h[9:0] / 1024.0;
    for (int i = 15; i < e; i++) begin
      m = m * 2.0;
    end
    for (int i = e; i < 15; i++) begin
      m = m / 2.0;
    end
    return h[15] ? -m : m;
  endfunction

  // Only exact values reach here, plus overflow
  function automatic logic [15:0] real_to_half(real x);
    logic s;
    int   e;
    real  m;
    s = (x < 0.0);
    m = s ? -x : x;
    e = 15;
    if (m >= 65520.0) begin
      return `CVP_FP_INF | {s, 15'd0};
    end
    if (m == 0.0) begin
      return 16'h0000;
    end
    while (m >= 2.0) begin
      m = m / 2.0;
      e++;
    end
    while (m < 1.0 && e > 1) begin
      m = m * 2.0;
      e--;
    end
    if (m < 1.0) begin
      return {s, 5'd0, 10'(int'(m * 1024.0))};  // Denormal
    end
    return {s, 5'(e), 10'(int'((m - 1.0) * 1024.0))};
  endfunction

  task automatic expect_store(int adr, logic [15:0] val);
    exp_mem[adr]   = val;
    exp_valid[adr] = 1'b1;
  endtask

  // Next fetch is the following word, or the J address plus its offset
  always @(posedge Clk1) begin
    if (rst_n && rd && addr < PROG_LEN) begin
      if (prog[addr[4:0]][15:12] == J) begin
        exp_fetch <= addr + {{4{prog[addr[4:0]][11]}}, prog[addr[4:0]][11:0]};
      end else begin
        exp_fetch <= addr + 16'd1;
      end
      if (addr == HALT_ADDR) begin
        halted <= 1'b1;
      end
    end
  end

  assert property (@(posedge Clk1) !rst_n |-> !rd && !wr && !v)
    else begin
      proto_errs++;
      $display("Memory strobe or overflow flag active during reset");
    end

  assert property (@(posedge Clk1) !(rd && wr))
    else begin
      proto_errs++;
      $display("Read and write strobes high in the same cycle");
    end

  assert property (@(posedge Clk1) disable iff (!rst_n)
      wr |-> addr[15:8] == 8'h00 && exp_valid[addr[7:0]])
    else begin
      proto_errs++;
      $display("Store to address %h that the program never writes", $sampled(addr));
    end

  assert property (@(posedge Clk1) disable iff (!rst_n) wr |-> data_out == exp_mem[addr[7:0]])
    else begin
      value_errs++;
      $display("FAILED data_out at %h: got %h, expected %h", $sampled(addr),
               $sampled(data_out), exp_mem[$sampled(addr[7:0])]);
    end

  assert property (@(posedge Clk1) disable iff (!rst_n) (rd && addr < PROG_LEN) |-> addr == exp_fetch)
    else begin
      value_errs++;
      $display("FAILED addr on fetch: got %h, expected %h", $sampled(addr), $sampled(exp_fetch));
    end

  assert property (@(posedge Clk1) disable iff (!rst_n)
      (rd && addr < PROG_LEN) |-> v == v_exp[addr[4:0]])
    else begin
      value_errs++;
      $display("FAILED v at fetch %h: got %h, expected %h", $sampled(addr), $sampled(v),
               v_exp[$sampled(addr[4:0])]);
    end

  initial begin : main
    logic [`CVP_WORD_W-1:0] a, b, c;
    int                     limit;
    int                     cycles;
    rst_n = 1'b0;
    void'($urandom(32'he305));
    for (int i = 0; i < 256; i++) begin
      exp_mem[i]   = '0;
      exp_valid[i] = 1'b0;
    end
    for (int i = 0; i < 32; i++) begin
      prog[i]  = {NOP, 12'h000};
      v_exp[i] = (i == 13 || i == 14);  // Between the overflowing and the clearing VADD
    end

    prog[0]  = {SLL, 3'd1, 9'h040};       // s1 source base
    prog[1]  = {SLL, 3'd2, 9'h080};       // s2 result base
    prog[2]  = {SLL, 3'd4, 9'h0C0};
    prog[3]  = {SLL, 3'd3, 9'h03C};
    prog[4]  = {SLH, 3'd3, 9'h0A5};
    prog[5]  = mem_instr(SST, 3, 4, 1);
    prog[6]  = mem_instr(VLD, 1, 1, 0);
    prog[7]  = mem_instr(VST, 1, 2, 0);   // Block copy
    prog[8]  = mem_instr(VLD, 2, 1, 16);
    prog[9]  = vadd_instr(3, 1, 2);
    prog[10] = mem_instr(VST, 3, 2, 16);
    prog[11] = mem_instr(VLD, 4, 1, 32);
    prog[12] = vadd_instr(5, 4, 4);       // Overflows in lanes 5 and 9
    prog[13] = mem_instr(VST, 5, 2, 32);
    prog[14] = vadd_instr(6, 1, 2);
    prog[15] = 16'hF6A5;                  // NOP whose fields name s3
    prog[16] = {J, 12'd2};
    prog[17] = mem_instr(SST, 3, 4, 2);   // Skipped
    prog[18] = mem_instr(SST, 3, 4, 3);
    prog[19] = {J, 12'd0};

    @(posedge Clk1);
    #DRIVE_DLY;
    for (int i = 0; i < PROG_LEN; i++) begin
      mem_i.mem[i] = prog[i];
    end
    for (int k = 0; k < `CVP_LANES; k++) begin
      // Same exponent and even fractions keep each sum exact
      a = {1'($urandom), 5'(1 + $urandom % 29), 6'($urandom), 4'd0};
      b = {a[15:10], 6'($urandom), 4'd0};
      c = {1'($urandom), 5'(1 + $urandom % 29), 6'($urandom), 4'd0};
      if ($urandom % 4 == 0) begin
        a = '0;
      end
      if (k == 5 || k == 9) begin
        c = {k == 9, 15'h7BFF};  // Largest finite magnitude
      end
      mem_i.mem['h40 + k] = a;
      mem_i.mem['h50 + k] = b;
      mem_i.mem['h60 + k] = c;
      expect_store('h80 + k, a);
      expect_store('h90 + k, real_to_half(half_to_real(a) + half_to_real(b)));
      expect_store('hA0 + k, real_to_half(half_to_real(c) + half_to_real(c)));
    end
    expect_store('hC1, 16'hA53C);
    expect_store('hC3, 16'hA53C);

    limit = 5 + MARGIN;
    for (int i = 0; i < PROG_LEN; i++) begin
      limit += instr_cycles(prog[i][15:12]);
    end

    repeat (4) @(posedge Clk1);
    #DRIVE_DLY rst_n = 1'b1;
    cycles = 5;
    while (!halted && cycles < limit) begin
      @(posedge Clk1);
      cycles++;
    end
    if (!halted) begin
      proto_errs++;
      $display("Timeout after %0d cycles without reaching the final jump", cycles);
    end
    @(posedge Clk1);
    #DRIVE_DLY;
    for (int i = 0; i < 256; i++) begin
      assert (!exp_valid[i] || mem_i.written[i])
        else begin
          miss_errs++;
          $display("Expected store to address %h never happened", i);
        end
    end

    $display("Errors: %0d value, %0d protocol, %0d missing stores",
             value_errs, proto_errs, miss_errs);
    if (value_errs + proto_errs + miss_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+logic
logic/cvp_pkg.sv
logic/fp16_adder.sv
logic/instr_decoder.sv
logic/register_bank.sv
logic/cvp_control.sv
logic/cvp_core.sv
testbench/cvp_mem_model.sv
testbench/cvp_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= cvp_tb
RTL_TOP   ?= cvp_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
